// ==== source/uart_pkg.sv ====
// UART bridge shared types for the receiver, byte FIFO and transmitter

package uart_pkg;

  ////////////////////////////////////////////////////////////
  // Data widths
  ////////////////////////////////////////////////////////////

  // One serial payload byte, sent and received LSB first
  typedef logic [7:0] uart_byte_t;

  // Position of a data bit inside the 8N1 frame
  typedef logic [2:0] bit_index_t;

  ////////////////////////////////////////////////////////////
  // Receiver to FIFO beat
  ////////////////////////////////////////////////////////////

  // Single-cycle strobe with its byte, no back-pressure
  typedef struct packed {
    logic       valid;  // High for one cycle per good frame
    uart_byte_t data;   // Byte decoded from that frame
  } rx_beat_t;

  ////////////////////////////////////////////////////////////
  // State machines
  ////////////////////////////////////////////////////////////

  // Receiver FSM, spare codes left for growth
  typedef enum logic [2:0] {
    RX_IDLE  = 3'd0,  // Waiting on a falling edge
    RX_START = 3'd1,  // Checking the middle of the start bit
    RX_DATA  = 3'd2,  // Sampling eight data bits
    RX_STOP  = 3'd3   // Checking the stop bit
  } rx_state_t;

  // Transmitter FSM, all four codes in use
  typedef enum logic [1:0] {
    TX_IDLE  = 2'd0,  // Line held high
    TX_START = 2'd1,  // Start bit low
    TX_DATA  = 2'd2,  // Data bits LSB first
    TX_STOP  = 2'd3   // Stop bit high
  } tx_state_t;

endpackage

// ==== source/uart_rx.sv ====
// UART 8N1 receiver that finds the start edge, samples mid-bit and strobes good bytes

module uart_rx #(
  parameter int RX_CLKS_PER_BIT = 8
) (
  input  logic               i_Clock,
  input  logic               i_rst_n,
  input  logic               i_rx_serial,
  output uart_pkg::rx_beat_t o_beat,
  output logic               o_frame_error
);

  import uart_pkg::*;

  // Bit timer sized from the receive rate
  localparam int TIMER_W = (RX_CLKS_PER_BIT > 1) ? $clog2(RX_CLKS_PER_BIT) : 1;
  localparam int HALF_BIT = (RX_CLKS_PER_BIT - 1) / 2;

  typedef logic [TIMER_W-1:0] rx_timer_t;

  localparam rx_timer_t LAST_TICK = rx_timer_t'(RX_CLKS_PER_BIT - 1);  // End of one bit
  localparam rx_timer_t MID_TICK  = rx_timer_t'(HALF_BIT);             // Middle of start bit
  localparam bit_index_t LAST_BIT = bit_index_t'(7);

  logic       rx_meta;   // First synchronizer flop
  logic       rx_sync;   // Line in the clock domain
  logic       rx_prev;   // Delayed copy for edge detect
  logic       start_edge;

  rx_state_t  rx_state;
  rx_timer_t  rx_timer;
  bit_index_t rx_index;
  uart_byte_t rx_shift;   // Bits shifted in from the top
  logic       beat_valid;

  ////////////////////////////////////////////////////////////
  // Line synchronizer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_Clock) begin
    if (!i_rst_n) begin
      rx_meta <= 1'b1;  // Idle line is high
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= i_rx_serial;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // High to low on the synchronized line
  assign start_edge = rx_prev & ~rx_sync;

  ////////////////////////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_Clock) begin
    if (!i_rst_n) begin
      rx_state      <= RX_IDLE;
      rx_timer      <= '0;
      rx_index      <= '0;
      beat_valid    <= 1'b0;
      o_frame_error <= 1'b0;
    end else begin
      beat_valid <= 1'b0;  // Strobe lasts one cycle
      case (rx_state)
        RX_IDLE: begin
          rx_timer <= '0;
          rx_index <= '0;
          if (start_edge) begin
            rx_state <= RX_START;
          end
        end

        // Glitch filter at mid start bit
        RX_START: begin
          if (rx_timer == MID_TICK) begin
            rx_timer <= '0;
            rx_state <= rx_sync ? RX_IDLE : RX_DATA;  // High here means a false start
          end else begin
            rx_timer <= rx_timer + rx_timer_t'(1);
          end
        end

        RX_DATA: begin
          if (rx_timer == LAST_TICK) begin
            rx_timer <= '0;  // Sample point reached
            if (rx_index == LAST_BIT) begin
              rx_state <= RX_STOP;
            end else begin
              rx_index <= rx_index + bit_index_t'(1);
            end
          end else begin
            rx_timer <= rx_timer + rx_timer_t'(1);
          end
        end

        // Stop bit decides between strobe and error
        RX_STOP: begin
          if (rx_timer == LAST_TICK) begin
            rx_timer <= '0;
            rx_state <= RX_IDLE;  // Back to edge hunting at once
            if (rx_sync) begin
              beat_valid <= 1'b1;
            end else begin
              o_frame_error <= 1'b1;  // Sticky until reset
            end
          end else begin
            rx_timer <= rx_timer + rx_timer_t'(1);
          end
        end

        default: rx_state <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first so new bits enter at the top
  always_ff @(posedge i_Clock) begin
    if (rx_state == RX_DATA && rx_timer == LAST_TICK) begin
      rx_shift <= {rx_sync, rx_shift[7:1]};
    end
  end

  assign o_beat = '{valid: beat_valid, data: rx_shift};  // Shift register holds during stop

endmodule

// ==== source/byte_fifo.sv ====
// Circular byte FIFO that drops writes when full and launches the idle transmitter

module byte_fifo #(
  parameter int FIFO_ADDR_BITS = 2
) (
  input  logic                 i_Clock,
  input  logic                 i_rst_n,
  input  uart_pkg::rx_beat_t   i_beat,
  input  logic                 i_tx_idle,
  output logic                 o_tx_start,
  output uart_pkg::uart_byte_t o_tx_byte,
  output logic                 o_overflow
);

  import uart_pkg::*;

  localparam int DEPTH = 1 << FIFO_ADDR_BITS;

  // Extra pointer bit tells full from empty
  typedef logic [FIFO_ADDR_BITS:0]   fifo_ptr_t;
  typedef logic [FIFO_ADDR_BITS-1:0] fifo_addr_t;

  uart_byte_t fifo_mem [DEPTH];
  fifo_ptr_t  wr_ptr;
  fifo_ptr_t  rd_ptr;
  fifo_addr_t wr_addr;
  fifo_addr_t rd_addr;
  logic       fifo_empty;
  logic       fifo_full;
  logic       push;
  logic       pop;

  ////////////////////////////////////////////////////////////
  // Status and handshake
  ////////////////////////////////////////////////////////////

  assign wr_addr    = wr_ptr[FIFO_ADDR_BITS-1:0];
  assign rd_addr    = rd_ptr[FIFO_ADDR_BITS-1:0];
  assign fifo_empty = (wr_ptr == rd_ptr);
  assign fifo_full  = (wr_addr == rd_addr) &&
                      (wr_ptr[FIFO_ADDR_BITS] != rd_ptr[FIFO_ADDR_BITS]);

  // Pop whenever data waits and the transmitter sits idle
  assign pop  = !fifo_empty && i_tx_idle;
  // A pop in the same cycle frees the head slot for this write
  assign push = i_beat.valid && (!fifo_full || pop);

  assign o_tx_start = pop;
  assign o_tx_byte  = fifo_mem[rd_addr];  // Head of queue

  ////////////////////////////////////////////////////////////
  // Pointers and flag
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_Clock) begin
    if (!i_rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      o_overflow <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + fifo_ptr_t'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + fifo_ptr_t'(1);
      end
      if (i_beat.valid && !push) begin
        o_overflow <= 1'b1;  // Byte lost, flag stays set
      end
    end
  end

  // Storage array
  always_ff @(posedge i_Clock) begin
    if (push) begin
      fifo_mem[wr_addr] <= i_beat.data;
    end
  end

endmodule

// ==== source/uart_tx.sv ====
// UART 8N1 transmitter with bit timer, shift index and one-cycle done pulse

module uart_tx #(
  parameter int TX_CLKS_PER_BIT = 16
) (
  input  logic                 i_Clock,
  input  logic                 i_rst_n,
  input  logic                 i_tx_start,
  input  uart_pkg::uart_byte_t i_tx_byte,
  output logic                 o_tx_serial,
  output logic                 o_tx_active,
  output logic                 o_tx_idle,
  output logic                 o_tx_done
);

  import uart_pkg::*;

  localparam int TIMER_W = (TX_CLKS_PER_BIT > 1) ? $clog2(TX_CLKS_PER_BIT) : 1;

  typedef logic [TIMER_W-1:0] tx_timer_t;

  localparam tx_timer_t  LAST_TICK = tx_timer_t'(TX_CLKS_PER_BIT - 1);
  localparam bit_index_t LAST_BIT  = bit_index_t'(7);

  tx_state_t  tx_state;
  tx_timer_t  tx_timer;    // Cycles into the current bit
  bit_index_t tx_index;    // Data bit on the line
  bit_index_t next_index;
  uart_byte_t tx_data;     // Byte latched at start

  assign next_index = tx_index + bit_index_t'(1);

  ////////////////////////////////////////////////////////////
  // Frame FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_Clock) begin
    if (!i_rst_n) begin
      tx_state    <= TX_IDLE;
      tx_timer    <= '0;
      tx_index    <= '0;
      o_tx_serial <= 1'b1;
      o_tx_done   <= 1'b0;
    end else begin
      o_tx_done <= 1'b0;  // Single-cycle pulse
      case (tx_state)
        TX_IDLE: begin
          o_tx_serial <= 1'b1;
          tx_timer    <= '0;
          tx_index    <= '0;
          if (i_tx_start) begin
            o_tx_serial <= 1'b0;  // Start bit on the next edge
            tx_state    <= TX_START;
          end
        end

        TX_START: begin
          if (tx_timer == LAST_TICK) begin
            tx_timer    <= '0;
            o_tx_serial <= tx_data[0];  // LSB goes first
            tx_state    <= TX_DATA;
          end else begin
            tx_timer <= tx_timer + tx_timer_t'(1);
          end
        end

        TX_DATA: begin
          if (tx_timer == LAST_TICK) begin
            tx_timer <= '0;
            if (tx_index == LAST_BIT) begin
              o_tx_serial <= 1'b1;  // Stop bit
              tx_state    <= TX_STOP;
            end else begin
              tx_index    <= next_index;
              o_tx_serial <= tx_data[next_index];
            end
          end else begin
            tx_timer <= tx_timer + tx_timer_t'(1);
          end
        end

        // Done rises with the return to idle
        TX_STOP: begin
          if (tx_timer == LAST_TICK) begin
            tx_timer  <= '0;
            o_tx_done <= 1'b1;
            tx_state  <= TX_IDLE;
          end else begin
            tx_timer <= tx_timer + tx_timer_t'(1);
          end
        end

        default: tx_state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_Clock) begin
    if (tx_state == TX_IDLE && i_tx_start) begin
      tx_data <= i_tx_byte;
    end
  end

  assign o_tx_active = (tx_state != TX_IDLE);  // Start through stop bit
  assign o_tx_idle   = (tx_state == TX_IDLE);

endmodule

// ==== source/uart_bridge.sv ====
// UART baud-rate bridge top that chains receiver, byte FIFO and transmitter

module uart_bridge #(
  parameter int RX_CLKS_PER_BIT = 8,
  parameter int TX_CLKS_PER_BIT = 16,
  parameter int FIFO_ADDR_BITS  = 2
) (
  input  logic i_Clock,
  input  logic i_rst_n,
  input  logic i_rx_serial,
  output logic o_tx_serial,
  output logic o_tx_active,
  output logic o_overflow,
  output logic o_frame_error
);

  import uart_pkg::*;

  rx_beat_t   rx_beat;   // Receiver strobe and byte
  logic       tx_start;  // FIFO pop and transmit launch
  uart_byte_t tx_byte;   // Head of FIFO
  logic       tx_idle;

  ////////////////////////////////////////////////////////////
  // Receive side at the input rate
  ////////////////////////////////////////////////////////////

  uart_rx #(
    .RX_CLKS_PER_BIT (RX_CLKS_PER_BIT)
  ) u_rx (
    .i_Clock       (i_Clock),
    .i_rst_n       (i_rst_n),
    .i_rx_serial   (i_rx_serial),
    .o_beat        (rx_beat),
    .o_frame_error (o_frame_error)
  );

  // Rate decoupling buffer
  byte_fifo #(
    .FIFO_ADDR_BITS (FIFO_ADDR_BITS)
  ) u_fifo (
    .i_Clock    (i_Clock),
    .i_rst_n    (i_rst_n),
    .i_beat     (rx_beat),
    .i_tx_idle  (tx_idle),
    .o_tx_start (tx_start),
    .o_tx_byte  (tx_byte),
    .o_overflow (o_overflow)
  );

  // Transmit side at the output rate
  uart_tx #(
    .TX_CLKS_PER_BIT (TX_CLKS_PER_BIT)
  ) u_tx (
    .i_Clock     (i_Clock),
    .i_rst_n     (i_rst_n),
    .i_tx_start  (tx_start),
    .i_tx_byte   (tx_byte),
    .o_tx_serial (o_tx_serial),
    .o_tx_active (o_tx_active),
    .o_tx_idle   (tx_idle),
    .o_tx_done   ()         // Completion pulse not needed here
  );

endmodule

// ==== bench/uart_bridge_tb.sv ====
// UART bridge testbench with serial driver, output decoder and directed tests

module uart_bridge_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import uart_pkg::*;

  // Same values as the DUT defaults
  localparam int RX_CLKS_PER_BIT = 8;
  localparam int TX_CLKS_PER_BIT = 16;
  localparam int FIFO_ADDR_BITS  = 2;
  localparam int DEPTH           = 1 << FIFO_ADDR_BITS;

  localparam int NUM_FRAMES     = 1 + 4 + 12 + 2;  // Frames driven by all tests
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * 10 * TX_CLKS_PER_BIT * 2;

  logic i_Clock = 1'b0;
  logic i_rst_n;
  logic i_rx_serial;
  logic o_tx_serial;
  logic o_tx_active;
  logic o_overflow;
  logic o_frame_error;

  int          errors      = 0;
  int          mon_errors  = 0;  // Protocol faults seen by the decoder
  int          checks      = 0;
  int          cycle_count = 0;
  logic [31:0] lcg_state   = 32'd81785;
  uart_byte_t  mon_data;
  uart_byte_t  tx_bytes[$];      // Bytes decoded from o_tx_serial

  uart_bridge DUT (
    .i_Clock       (i_Clock),
    .i_rst_n       (i_rst_n),
    .i_rx_serial   (i_rx_serial),
    .o_tx_serial   (o_tx_serial),
    .o_tx_active   (o_tx_active),
    .o_overflow    (o_overflow),
    .o_frame_error (o_frame_error)
  );

  always #4 i_Clock = ~i_Clock;  // 8 ns period

  ////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////

  always @(posedge i_Clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output decoder at the send rate
  ////////////////////////////////////////////////////////////

  always begin
    @(negedge i_Clock);
    if (i_rst_n === 1'b1 && o_tx_serial === 1'b0) begin
      repeat (TX_CLKS_PER_BIT / 2 - 1) @(negedge i_Clock);  // Middle of start bit
      if (o_tx_serial !== 1'b0) begin
        mon_errors++;
        $display("Monitor: start bit on o_tx_serial did not stay low");
      end else begin
        for (int i = 0; i < 8; i++) begin
          repeat (TX_CLKS_PER_BIT) @(negedge i_Clock);
          mon_data = {o_tx_serial, mon_data[7:1]};  // LSB first
        end
        repeat (TX_CLKS_PER_BIT) @(negedge i_Clock);
        if (o_tx_serial === 1'b1) begin
          tx_bytes.push_back(mon_data);
        end else begin
          mon_errors++;
          $display("Monitor: stop bit on o_tx_serial was low");
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // LCG step, middle bits carry the best spread
  function automatic uart_byte_t next_random_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic apply_reset();
    i_rst_n = 1'b0;
    repeat (2) @(negedge i_Clock);
    i_rst_n = 1'b1;
  endtask

  // One frame at the receive rate, caller sits on a falling edge
  task automatic drive_frame(input uart_byte_t data, input logic stop_bit);
    logic [9:0] frame;
    frame = {stop_bit, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      i_rx_serial = frame[0];
      frame = frame >> 1;
      repeat (RX_CLKS_PER_BIT) @(negedge i_Clock);
    end
    i_rx_serial = 1'b1;  // Back to idle
  endtask

  task automatic send_byte(input uart_byte_t data);
    drive_frame(data, 1'b1);
  endtask

  task automatic send_bad_frame(input uart_byte_t data);
    drive_frame(data, 1'b0);
  endtask

  // Transmitter quiet for two bit times means the FIFO has drained
  task automatic wait_idle();
    int quiet;
    quiet = 0;
    while (quiet < TX_CLKS_PER_BIT * 2) begin
      @(negedge i_Clock);
      if (o_tx_active) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic idle_after_reset();
    int lows;
    lows = 0;
    check("reset tx_serial", 32'(1), 32'(o_tx_serial));
    check("reset tx_active", 32'(0), 32'(o_tx_active));
    check("reset overflow", 32'(0), 32'(o_overflow));
    check("reset frame_error", 32'(0), 32'(o_frame_error));
    repeat (50) begin
      @(negedge i_Clock);
      if (o_tx_serial !== 1'b1) lows++;
    end
    check("idle line", 32'(0), 32'(lows));
  endtask

  task automatic single_byte_roundtrip();
    int base;
    int lead;
    int busy;
    base = tx_bytes.size();
    send_byte(8'hA5);
    lead = 0;
    while (o_tx_active !== 1'b1 && lead < TX_CLKS_PER_BIT) begin
      @(negedge i_Clock);
      lead++;
    end
    // Active covers start, eight data and stop bits, then falls
    busy = 0;
    while (o_tx_active === 1'b1) begin
      busy++;
      @(negedge i_Clock);
    end
    check("single active cycles", 32'(10 * TX_CLKS_PER_BIT), 32'(busy));
    wait_idle();
    check("single count", 32'(1), 32'(tx_bytes.size() - base));
    if (tx_bytes.size() > base) check("single data", 32'(8'hA5), 32'(tx_bytes[base]));
  endtask

  task automatic burst_keeps_order();
    uart_byte_t sent[$];
    int         base;
    base = tx_bytes.size();
    for (int i = 0; i < 4; i++) begin
      sent.push_back(next_random_byte());
      send_byte(sent[i]);
    end
    wait_idle();
    check("burst count", 32'(4), 32'(tx_bytes.size() - base));
    for (int i = 0; i < 4 && base + i < tx_bytes.size(); i++) begin
      check($sformatf("burst byte %0d", i), 32'(sent[i]), 32'(tx_bytes[base + i]));
    end
    check("burst overflow", 32'(0), 32'(o_overflow));
  endtask

  task automatic overflow_drops_bytes();
    uart_byte_t sent[$];
    int         base;
    int         pos;
    int         got;
    logic       ordered;
    base = tx_bytes.size();
    for (int i = 0; i < 12; i++) begin
      sent.push_back(next_random_byte());
      send_byte(sent[i]);
    end
    wait_idle();
    got = tx_bytes.size() - base;
    check("overflow flag", 32'(1), 32'(o_overflow));
    check("overflow count min", 32'(1), 32'(got >= DEPTH + 1));
    check("overflow count max", 32'(1), 32'(got < 12));
    // Each output byte must match a later sent byte than the one before
    ordered = 1'b1;
    pos = 0;
    for (int i = base; i < tx_bytes.size(); i++) begin
      while (pos < sent.size() && sent[pos] != tx_bytes[i]) pos++;
      if (pos == sent.size()) ordered = 1'b0;
      else pos++;
    end
    check("overflow order", 32'(1), 32'(ordered));
  endtask

  task automatic bad_stop_bit_dropped();
    uart_byte_t good;
    int         base;
    apply_reset();
    check("clear overflow", 32'(0), 32'(o_overflow));
    base = tx_bytes.size();
    good = next_random_byte();
    send_bad_frame(8'h3C);
    repeat (RX_CLKS_PER_BIT * 2) @(negedge i_Clock);  // Idle gap so a new edge appears
    send_byte(good);
    wait_idle();
    check("frame_error flag", 32'(1), 32'(o_frame_error));
    check("frame_error count", 32'(1), 32'(tx_bytes.size() - base));
    if (tx_bytes.size() > base) check("frame_error data", 32'(good), 32'(tx_bytes[base]));
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////

  initial begin
    i_rst_n     = 1'b0;
    i_rx_serial = 1'b1;
    apply_reset();
    idle_after_reset();
    single_byte_roundtrip();
    burst_keeps_order();
    overflow_drops_bytes();
    bad_stop_bit_dropped();
    errors = errors + mon_errors;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
source/uart_pkg.sv
source/uart_rx.sv
source/byte_fifo.sv
source/uart_tx.sv
source/uart_bridge.sv
bench/uart_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the UART bridge testbench with Verilator and run it

set -e

cd "$(dirname "$0")"

verilator --binary -f sim.f --top-module uart_bridge_tb \
  --Mdir obj_dir -o sim_uart_bridge

./obj_dir/sim_uart_bridge | tee sim.log

if grep -q "Done: no errors" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
